// File: design/fftPkg.sv
`default_nettype none

package fftPkg;

    localparam int sampleW = 16;
    localparam int twiddleFrac = 14;
    localparam int maxPoints = 16;

    typedef struct packed {
        logic signed [sampleW-1:0] re;
        logic signed [sampleW-1:0] im;
    } complexSample;

    typedef struct packed {
        complexSample a;
        complexSample b;
        complexSample w;
    } butterflyPair;

    typedef struct packed {
        complexSample x;
        complexSample y;
    } butterflyResult;

    typedef enum logic {
        OP_FFT,
        OP_IFFT
    } fftOp;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        COMPUTE,
        WRITEBACK,
        UNLOAD,
        DONE
    } ctrlState;

    //////////////////////////////////////////////////////////////////////
    // Twiddles for a 16 point circle, Q1.14
    //////////////////////////////////////////////////////////////////////
    localparam complexSample twiddleTable [maxPoints/2] = '{
        '{16'sd16384, 16'sd0},
        '{16'sd15137, -16'sd6270},
        '{16'sd11585, -16'sd11585},
        '{16'sd6270, -16'sd15137},
        '{16'sd0, -16'sd16384},
        '{-16'sd6270, -16'sd15137},
        '{-16'sd11585, -16'sd11585},
        '{-16'sd15137, -16'sd6270}
    };

endpackage

`default_nettype wire

// File: design/butterflyUnit.sv
`timescale 1ns/1ps
`default_nettype none

module butterflyUnit (
    input  fftPkg::butterflyPair   pair,
    output fftPkg::butterflyResult result
);
    import fftPkg::*;

    localparam int prodW = 2 * sampleW;
    localparam int sumW = 2 * sampleW + 2;

    logic signed [prodW-1:0] rr;
    logic signed [prodW-1:0] ii;
    logic signed [prodW-1:0] ri;
    logic signed [prodW-1:0] ir;
    logic signed [sumW-1:0] pRe;
    logic signed [sumW-1:0] pIm;
    logic signed [sumW-1:0] xRe;
    logic signed [sumW-1:0] xIm;
    logic signed [sumW-1:0] yRe;
    logic signed [sumW-1:0] yIm;

    // w * b, every partial product floored on its own
    assign rr = pair.w.re * pair.b.re;
    assign ii = pair.w.im * pair.b.im;
    assign ri = pair.w.re * pair.b.im;
    assign ir = pair.w.im * pair.b.re;
    assign pRe = (rr >>> twiddleFrac) - (ii >>> twiddleFrac);
    assign pIm = (ri >>> twiddleFrac) + (ir >>> twiddleFrac);

    // Halve every stage
    assign xRe = (pair.a.re + pRe) >>> 1;
    assign xIm = (pair.a.im + pIm) >>> 1;
    assign yRe = (pair.a.re - pRe) >>> 1;
    assign yIm = (pair.a.im - pIm) >>> 1;

    assign result.x.re = xRe[sampleW-1:0];
    assign result.x.im = xIm[sampleW-1:0];
    assign result.y.re = yRe[sampleW-1:0];
    assign result.y.im = yIm[sampleW-1:0];

endmodule

`default_nettype wire

// File: design/sampleBank.sv
`timescale 1ns/1ps
`default_nettype none

module sampleBank #(
    parameter int fftPoints = 8
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     loadEn,
    input  logic [$clog2($clog2(fftPoints))-1:0]     stageIdx,
    input  logic                                     isIfft,
    input  logic                                     inReq,
    input  fftPkg::complexSample                     inData,
    output logic                                     inAck,
    output logic                                     loadDone,
    output fftPkg::butterflyPair [fftPoints/2-1:0]   pairs,
    input  logic                                     writeEn,
    input  fftPkg::butterflyResult [fftPoints/2-1:0] writeData,
    input  logic [$clog2(fftPoints)-1:0]             readIdx,
    output fftPkg::complexSample                     readData
);
    import fftPkg::*;

    localparam int numPairs = fftPoints / 2;
    localparam int addrW = $clog2(fftPoints);

    complexSample mem [fftPoints];
    logic [addrW-1:0] loadCount;
    logic [addrW-1:0] loAddr [numPairs];
    logic [addrW-1:0] hiAddr [numPairs];
    complexSample twiddle [numPairs];
    logic takeSample;

    function automatic logic [addrW-1:0] bitRev(input logic [addrW-1:0] idx);
        logic [addrW-1:0] rev;
        for (int b = 0; b < addrW; b++) begin
            rev[b] = idx[addrW-1-b];
        end
        return rev;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Input handshake
    //////////////////////////////////////////////////////////////////////
    assign takeSample = loadEn && inReq && !inAck;
    // Strobe on the cycle where ack falls for the last sample
    assign loadDone = loadEn && inAck && !inReq && (loadCount == addrW'(fftPoints - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inAck <= 1'b0;
            loadCount <= '0;
        end else if (takeSample) begin
            inAck <= 1'b1;
        end else if (inAck && !inReq) begin
            inAck <= 1'b0;
            loadCount <= loadCount + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operand addressing per stage
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        int span;
        int lo;
        span = 1 << stageIdx;
        for (int j = 0; j < numPairs; j++) begin
            // Insert a zero at bit position stageIdx of j
            lo = ((j >> stageIdx) << (stageIdx + 1)) | (j & (span - 1));
            loAddr[j] = addrW'(lo);
            hiAddr[j] = addrW'(lo + span);
            twiddle[j] = twiddleTable[(j & (span - 1)) * ((maxPoints / 2) >> stageIdx)];
            if (isIfft) begin
                twiddle[j].im = -twiddle[j].im;
            end
        end
    end

    always_comb begin
        for (int j = 0; j < numPairs; j++) begin
            pairs[j].a = mem[loAddr[j]];
            pairs[j].b = mem[hiAddr[j]];
            pairs[j].w = twiddle[j];
        end
    end

    // In-place update, same addresses as the operands
    always_ff @(posedge clk) begin
        if (takeSample) begin
            mem[bitRev(loadCount)] <= inData;
        end else if (writeEn) begin
            for (int j = 0; j < numPairs; j++) begin
                mem[loAddr[j]] <= writeData[j].x;
                mem[hiAddr[j]] <= writeData[j].y;
            end
        end
    end

    assign readData = mem[readIdx];

    assert property (@(posedge clk) disable iff (rst)
        (inReq && !inAck) |=> (!inReq || $stable(inData)))
        else $error("sampleBank: inData changed before ack");

endmodule

`default_nettype wire

// File: design/resultCollector.sv
`timescale 1ns/1ps
`default_nettype none

module resultCollector #(
    parameter int fftPoints = 8
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  fftPkg::butterflyResult [fftPoints/2-1:0] results,
    input  logic                                     computeEn,
    input  logic                                     writeEn,
    output fftPkg::butterflyResult [fftPoints/2-1:0] writeData,
    output logic                                     writeDone,
    input  logic                                     unloadEn,
    output logic [$clog2(fftPoints)-1:0]             readIdx,
    input  fftPkg::complexSample                     readData,
    output logic                                     outReq,
    input  logic                                     outAck,
    output fftPkg::complexSample                     outData,
    output logic                                     unloadDone
);
    import fftPkg::*;

    localparam int numPairs = fftPoints / 2;
    localparam int addrW = $clog2(fftPoints);

    butterflyResult [numPairs-1:0] resultReg;
    logic resultValid;
    logic lastSent;
    logic startXfer;
    logic endXfer;

    //////////////////////////////////////////////////////////////////////
    // Stage results
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (computeEn) begin
            resultReg <= results;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else if (computeEn) begin
            resultValid <= 1'b1;
        end else if (writeEn) begin
            resultValid <= 1'b0;
        end
    end

    assign writeData = resultReg;
    assign writeDone = writeEn && resultValid;

    //////////////////////////////////////////////////////////////////////
    // Output handshake, natural order
    //////////////////////////////////////////////////////////////////////
    assign startXfer = unloadEn && !outReq && !outAck && !lastSent;
    assign endXfer = outReq && outAck;
    // Ack of the final sample has fallen
    assign unloadDone = unloadEn && lastSent && !outReq && !outAck;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outReq <= 1'b0;
            readIdx <= '0;
            lastSent <= 1'b0;
        end else if (startXfer) begin
            outReq <= 1'b1;
        end else if (endXfer) begin
            outReq <= 1'b0;
            readIdx <= readIdx + 1'b1;
            if (readIdx == addrW'(fftPoints - 1)) begin
                lastSent <= 1'b1;
            end
        end else if (unloadDone) begin
            lastSent <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (startXfer) begin
            outData <= readData;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $rose(outReq) |-> !$past(outAck))
        else $error("resultCollector: outReq raised while outAck high");

endmodule

`default_nettype wire

// File: design/fftControl.sv
`timescale 1ns/1ps
`default_nettype none

module fftControl #(
    parameter int fftPoints = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cmdReq,
    input  fftPkg::fftOp                         cmdOp,
    output logic                                 cmdAck,
    input  logic                                 loadDone,
    input  logic                                 writeDone,
    input  logic                                 unloadDone,
    output logic                                 loadEn,
    output logic                                 computeEn,
    output logic                                 writeEn,
    output logic                                 unloadEn,
    output logic [$clog2($clog2(fftPoints))-1:0] stageIdx,
    output logic                                 isIfft,
    output logic                                 busy,
    output logic                                 done
);
    import fftPkg::*;

    localparam int numStages = $clog2(fftPoints);

    ctrlState state;
    ctrlState nextState;
    fftOp opReg;
    logic accept;
    logic lastStage;

    // New job only from IDLE, and only once the previous ack has dropped
    assign accept = (state == IDLE) && cmdReq && !cmdAck;
    assign lastStage = (stageIdx == numStages - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            opReg <= OP_FFT;
            cmdAck <= 1'b0;
            stageIdx <= '0;
        end else begin
            state <= nextState;
            if (accept) begin
                cmdAck <= 1'b1;
                opReg <= cmdOp;
            end else if (!cmdReq) begin
                cmdAck <= 1'b0;
            end
            if (state == IDLE) begin
                stageIdx <= '0;
            end else if ((state == WRITEBACK) && writeDone && !lastStage) begin
                stageIdx <= stageIdx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    nextState = LOAD;
                end
            end
            LOAD: begin
                if (loadDone) begin
                    nextState = COMPUTE;
                end
            end
            COMPUTE: begin
                nextState = WRITEBACK;
            end
            WRITEBACK: begin
                if (writeDone) begin
                    nextState = lastStage ? UNLOAD : COMPUTE;
                end
            end
            UNLOAD: begin
                if (unloadDone) begin
                    nextState = DONE;
                end
            end
            DONE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    assign loadEn = (state == LOAD);
    assign computeEn = (state == COMPUTE);
    assign writeEn = (state == WRITEBACK);
    assign unloadEn = (state == UNLOAD);
    assign done = (state == DONE);
    assign busy = (state != IDLE) && (state != DONE);
    assign isIfft = (opReg == OP_IFFT);

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({loadEn, computeEn, writeEn, unloadEn}))
        else $error("fftControl: more than one phase enable active");

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("fftControl: done longer than one cycle");

endmodule

`default_nettype wire

// File: design/fftTop.sv
`timescale 1ns/1ps
`default_nettype none

module fftTop #(
    parameter int fftPoints = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmdReq,
    output logic                 cmdAck,
    input  fftPkg::fftOp         cmdOp,
    input  logic                 inReq,
    output logic                 inAck,
    input  fftPkg::complexSample inData,
    output logic                 outReq,
    input  logic                 outAck,
    output fftPkg::complexSample outData,
    output logic                 busy,
    output logic                 done
);
    import fftPkg::*;

    localparam int numPairs = fftPoints / 2;
    localparam int numStages = $clog2(fftPoints);

    logic loadEn;
    logic computeEn;
    logic writeEn;
    logic unloadEn;
    logic [$clog2(numStages)-1:0] stageIdx;
    logic isIfft;
    logic loadDone;
    logic writeDone;
    logic unloadDone;
    butterflyPair [numPairs-1:0] pairs;
    butterflyResult [numPairs-1:0] results;
    butterflyResult [numPairs-1:0] writeData;
    logic [$clog2(fftPoints)-1:0] readIdx;
    complexSample readData;

    fftControl #(.fftPoints(fftPoints)) uControl (
        .clk(clk),
        .rst(rst),
        .cmdReq(cmdReq),
        .cmdOp(cmdOp),
        .cmdAck(cmdAck),
        .loadDone(loadDone),
        .writeDone(writeDone),
        .unloadDone(unloadDone),
        .loadEn(loadEn),
        .computeEn(computeEn),
        .writeEn(writeEn),
        .unloadEn(unloadEn),
        .stageIdx(stageIdx),
        .isIfft(isIfft),
        .busy(busy),
        .done(done)
    );

    sampleBank #(.fftPoints(fftPoints)) uBank (
        .clk(clk),
        .rst(rst),
        .loadEn(loadEn),
        .stageIdx(stageIdx),
        .isIfft(isIfft),
        .inReq(inReq),
        .inData(inData),
        .inAck(inAck),
        .loadDone(loadDone),
        .pairs(pairs),
        .writeEn(writeEn),
        .writeData(writeData),
        .readIdx(readIdx),
        .readData(readData)
    );

    // One butterfly per operand pair
    for (genvar g = 0; g < numPairs; g++) begin : gBfly
        butterflyUnit uBfly (
            .pair(pairs[g]),
            .result(results[g])
        );
    end

    resultCollector #(.fftPoints(fftPoints)) uCollector (
        .clk(clk),
        .rst(rst),
        .results(results),
        .computeEn(computeEn),
        .writeEn(writeEn),
        .writeData(writeData),
        .writeDone(writeDone),
        .unloadEn(unloadEn),
        .readIdx(readIdx),
        .readData(readData),
        .outReq(outReq),
        .outAck(outAck),
        .outData(outData),
        .unloadDone(unloadDone)
    );

endmodule

`default_nettype wire

// File: dv/fftChecker.sv
`timescale 1ns/1ps
`default_nettype none

module fftChecker #(
    parameter int fftPoints = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmdAck,
    input  logic                 inAck,
    input  logic                 outReq,
    input  logic                 outAck,
    input  fftPkg::complexSample outData,
    input  logic                 busy,
    input  logic                 done
);
    import fftPkg::*;

    complexSample expQ [$];
    int valueErrors = 0;
    int protocolErrors = 0;
    int outCount = 0;
    int jobsDone = 0;
    logic doneSeen = 1'b0;

    task automatic expectSample(input complexSample s);
        expQ.push_back(s);
    endtask

    task automatic finalCheck(input int jobs);
        if (jobsDone != jobs) begin
            protocolErrors++;
            $display("Saw %0d done pulses for %0d jobs", jobsDone, jobs);
        end
        if (expQ.size() != 0) begin
            protocolErrors++;
            $display("%0d expected samples never came out", expQ.size());
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Port monitor
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : watch
        complexSample want;
        if (rst) begin
            if ({busy, cmdAck, inAck, outReq, done} !== 5'b00000) begin
                protocolErrors++;
                $display("At %0t an output is not low during reset", $time);
            end
        end else begin
            // One edge with both high per output transfer
            if (outReq && outAck) begin
                if (expQ.size() == 0) begin
                    protocolErrors++;
                    $display("At %0t an output transfer came with nothing expected", $time);
                end else begin
                    want = expQ.pop_front();
                    if (outData.re !== want.re) begin
                        valueErrors++;
                        $display("ERR %0t outData.re expected %0d got %0d",
                                 $time, want.re, outData.re);
                    end
                    if (outData.im !== want.im) begin
                        valueErrors++;
                        $display("ERR %0t outData.im expected %0d got %0d",
                                 $time, want.im, outData.im);
                    end
                end
                outCount++;
            end
            if (done) begin
                if (doneSeen) begin
                    protocolErrors++;
                    $display("At %0t done stayed high for more than one cycle", $time);
                end
                if (outCount != fftPoints) begin
                    protocolErrors++;
                    $display("At %0t done came after %0d output transfers", $time, outCount);
                end
                if (busy) begin
                    protocolErrors++;
                    $display("At %0t busy is still high with done", $time);
                end
                outCount = 0;
                jobsDone++;
            end
            doneSeen = done;
        end
    end

endmodule

`default_nettype wire

// File: dv/fftTb.sv
`timescale 1ns/1ps
`default_nettype none

module fftTb;
    import fftPkg::*;

    localparam int fftPoints = 8;
    localparam int numStages = $clog2(fftPoints);
    localparam int waitLimit = 200;
    localparam int numMixedJobs = 20;
    localparam int selCmdAck = 0;
    localparam int selInAck = 1;
    localparam int selOutReq = 2;
    localparam int selDone = 3;

    logic clk;
    logic rst;
    logic cmdReq;
    logic cmdAck;
    fftOp cmdOp;
    logic inReq;
    logic inAck;
    complexSample inData;
    logic outReq;
    logic outAck;
    complexSample outData;
    logic busy;
    logic done;

    int seed;
    int modelErrors;
    int jobCount;
    int twRe [maxPoints/2];
    int twIm [maxPoints/2];
    complexSample stimulus [fftPoints];
    logic signed [sampleW-1:0] mRe [fftPoints];
    logic signed [sampleW-1:0] mIm [fftPoints];

    fftTop #(.fftPoints(fftPoints)) UUT (
        .clk(clk),
        .rst(rst),
        .cmdReq(cmdReq),
        .cmdAck(cmdAck),
        .cmdOp(cmdOp),
        .inReq(inReq),
        .inAck(inAck),
        .inData(inData),
        .outReq(outReq),
        .outAck(outAck),
        .outData(outData),
        .busy(busy),
        .done(done)
    );

    fftChecker #(.fftPoints(fftPoints)) uChecker (
        .clk(clk),
        .rst(rst),
        .cmdAck(cmdAck),
        .inAck(inAck),
        .outReq(outReq),
        .outAck(outAck),
        .outData(outData),
        .busy(busy),
        .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int randBelow(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    function automatic int roundNearest(input real r);
        return (r >= 0.0) ? $rtoi(r + 0.5) : -$rtoi(-r + 0.5);
    endfunction

    function automatic int bitReverse(input int idx);
        int rev;
        rev = 0;
        for (int b = 0; b < numStages; b++) begin
            rev = (rev << 1) | ((idx >> b) & 1);
        end
        return rev;
    endfunction

    // cos and -sin of 2*pi*k/16 in Q1.14
    function automatic void buildTwiddles();
        real ang;
        for (int k = 0; k < maxPoints / 2; k++) begin
            ang = 2.0 * 3.14159265358979 * k / maxPoints;
            twRe[k] = roundNearest($cos(ang) * 16384.0);
            twIm[k] = roundNearest(-$sin(ang) * 16384.0);
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // In-place radix-2 reference model with halving per stage
    //////////////////////////////////////////////////////////////////////
    function automatic void runModel(input logic inverse);
        longint wr;
        longint wi;
        longint aRe;
        longint aIm;
        longint bRe;
        longint bIm;
        longint pRe;
        longint pIm;
        int span;
        int lo;
        int tw;
        for (int k = 0; k < fftPoints; k++) begin
            mRe[bitReverse(k)] = stimulus[k].re;
            mIm[bitReverse(k)] = stimulus[k].im;
        end
        for (int s = 0; s < numStages; s++) begin
            span = 1 << s;
            for (int base = 0; base < fftPoints; base += 2 * span) begin
                for (int k = 0; k < span; k++) begin
                    lo = base + k;
                    tw = k * (maxPoints / (2 * span));
                    wr = twRe[tw];
                    wi = inverse ? -twIm[tw] : twIm[tw];
                    aRe = mRe[lo];
                    aIm = mIm[lo];
                    bRe = mRe[lo + span];
                    bIm = mIm[lo + span];
                    pRe = ((wr * bRe) >>> twiddleFrac) - ((wi * bIm) >>> twiddleFrac);
                    pIm = ((wr * bIm) >>> twiddleFrac) + ((wi * bRe) >>> twiddleFrac);
                    mRe[lo] = sampleW'((aRe + pRe) >>> 1);
                    mIm[lo] = sampleW'((aIm + pIm) >>> 1);
                    mRe[lo + span] = sampleW'((aRe - pRe) >>> 1);
                    mIm[lo + span] = sampleW'((aIm - pIm) >>> 1);
                end
            end
        end
    endfunction

    task automatic endRun(input logic timedOut);
        int total;
        total = uChecker.valueErrors + uChecker.protocolErrors + modelErrors + timedOut;
        $display("Error counts: value %0d, protocol %0d, model %0d, timeout %0d",
                 uChecker.valueErrors, uChecker.protocolErrors, modelErrors, timedOut);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    function automatic logic pick(input int sel);
        case (sel)
            selCmdAck: return cmdAck;
            selInAck: return inAck;
            selOutReq: return outReq;
            default: return done;
        endcase
    endfunction

    // Every call starts and ends 1 ns after a rising edge
    task automatic waitFor(input int sel, input logic level, input string what);
        int cycles;
        cycles = 0;
        while ((pick(sel) !== level) && (cycles < waitLimit)) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pick(sel) !== level) begin
            $display("Timeout at %0t waiting for %s", $time, what);
            endRun(1'b1);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic sendCommand(input fftOp op);
        idleCycles(randBelow(3));
        cmdOp = op;
        cmdReq = 1'b1;
        waitFor(selCmdAck, 1'b1, "cmdAck to rise");
        cmdReq = 1'b0;
        waitFor(selCmdAck, 1'b0, "cmdAck to fall");
    endtask

    task automatic sendSamples();
        for (int k = 0; k < fftPoints; k++) begin
            idleCycles(randBelow(4));
            inData = stimulus[k];
            inReq = 1'b1;
            waitFor(selInAck, 1'b1, "inAck to rise");
            idleCycles(randBelow(3));
            inReq = 1'b0;
            waitFor(selInAck, 1'b0, "inAck to fall");
        end
    endtask

    // Environment side of the out port with random back-pressure
    task automatic collectOutputs();
        for (int k = 0; k < fftPoints; k++) begin
            waitFor(selOutReq, 1'b1, "outReq to rise");
            idleCycles(randBelow(5));
            outAck = 1'b1;
            waitFor(selOutReq, 1'b0, "outReq to fall");
            idleCycles(randBelow(3));
            outAck = 1'b0;
        end
    endtask

    task automatic runJob(input fftOp op, input logic impulse);
        complexSample s;
        for (int k = 0; k < fftPoints; k++) begin
            if (impulse) begin
                stimulus[k].re = (k == 0) ? 16'sd32767 : 16'sd0;
                stimulus[k].im = '0;
            end else begin
                stimulus[k].re = sampleW'($random(seed));
                stimulus[k].im = sampleW'($random(seed));
            end
        end
        runModel(op == OP_IFFT);
        for (int k = 0; k < fftPoints; k++) begin
            s.re = mRe[k];
            s.im = mIm[k];
            uChecker.expectSample(s);
            // Impulse gives a flat output halved once per stage
            if (impulse && ((mRe[k] != (32767 >>> numStages)) || (mIm[k] != 0))) begin
                modelErrors++;
                $display("Model gave %0d, %0d at bin %0d for the impulse", mRe[k], mIm[k], k);
            end
        end
        sendCommand(op);
        sendSamples();
        collectOutputs();
        waitFor(selDone, 1'b1, "done pulse");
        jobCount++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        seed = 96214;
        modelErrors = 0;
        jobCount = 0;
        rst = 1'b1;
        cmdReq = 1'b0;
        cmdOp = OP_FFT;
        inReq = 1'b0;
        inData = '0;
        outAck = 1'b0;
        buildTwiddles();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        runJob(OP_FFT, 1'b0);
        runJob(OP_IFFT, 1'b0);
        runJob(OP_IFFT, 1'b1);
        for (int j = 0; j < numMixedJobs; j++) begin
            runJob((randBelow(2) == 1) ? OP_IFFT : OP_FFT, 1'b0);
        end

        idleCycles(2);
        uChecker.finalCheck(jobCount);
        endRun(1'b0);
    end

endmodule

`default_nettype wire

// File: verilog.f
design/fftPkg.sv
design/butterflyUnit.sv
design/sampleBank.sv
design/resultCollector.sv
design/fftControl.sv
design/fftTop.sv
dv/fftChecker.sv
dv/fftTb.sv
